/* miniCoreAccelTop.f */
+incdir+source
source/accelTilePkg.sv
source/accelTileFabricPort.sv
source/accelTileMemWrap.sv
source/accelFarm.sv
source/miniCoreAccelTop.sv
tb/miniCoreAccelTopAssertions.sv
tb/miniCoreAccelTopTb.sv

/* Bender.yml */
package:
  name: mini_core_accel_top

export_include_dirs:
  - source

sources:
  - source/accelTilePkg.sv
  - source/accelTileFabricPort.sv
  - source/accelTileMemWrap.sv
  - source/accelFarm.sv
  - source/miniCoreAccelTop.sv
  - target: test
    files:
      - tb/miniCoreAccelTopAssertions.sv
      - tb/miniCoreAccelTopTb.sv

/* tb/miniCoreAccelTopTb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "accel_tile_macros.svh"

module miniCoreAccelTopTb;

   localparam int NumMemWords = 300;
   localparam int NumMulIter  = 40;
   localparam int NumMacRound = 4;
   localparam int NumMixed    = 200;
   localparam int NumBpReads  = 100;
   // a mac round sends at most a load, 31 steps of 3 writes and one read
   localparam int TotalTrans  = 2 * NumMemWords + 4 * NumMulIter + NumMacRound * (2 + 3 * 31)
                                + NumMixed + NumBpReads;
   localparam int CycleLimit  = TotalTrans * 8 + 200;

   logic                       Clock;
   logic                       reset;
   accelTilePkg::tTileId       localTileId;
   logic                       InFabricValid;
   accelTilePkg::tTileTrans    InFabric;
   logic                       miniCoreReady;
   logic                       OutFabricValid;
   accelTilePkg::tTileTrans    OutFabric;
   logic                       fabReady;

   logic [31:0]                modelMem [`ACCEL_DMEM_WORDS];
   logic [7:0]                 wrList [$];       // word indices holding known data
   accelTilePkg::tAccelOperand modelA;
   accelTilePkg::tAccelOperand modelB;
   logic signed [31:0]         modelAcc;
   accelTilePkg::tTileTrans    expQ [$];         // responses in request order
   accelTilePkg::tTileTrans    expRsp;
   logic [31:0]                stimState;
   logic [31:0]                readyState;
   logic                       longStretches;
   int                         stretchLeft;
   int                         errorCount;
   int                         testsPassed;
   int                         testsFailed;
   int                         localReads;
   int                         rspSeen;
   int                         cycleCount;

   miniCoreAccelTop i_miniCoreAccelTop (.*);

   bind miniCoreAccelTop miniCoreAccelTopAssertions i_miniCoreAccelTopAssertions (.*);

   initial begin
      Clock = 1'b0;
      forever #4 Clock = ~Clock;
   end

   // ==========================================================
   // random source and model
   // ==========================================================
   function automatic logic [31:0] takeBits(inout logic [31:0] state, input int n);
      logic [31:0] bits;
      logic        fb;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         fb    = state[31] ^ state[21] ^ state[1] ^ state[0];  // taps 32 22 2 1
         state = {state[30:0], fb};
         bits  = {bits[30:0], fb};
      end
      return bits;
   endfunction

   function automatic int laneProduct(input int i);
      return int'(modelA.lane[i]) * int'(modelB.lane[i]);  // signed int8 lane product
   endfunction

   function automatic logic [15:0] memAddr(input logic [7:0] idx);
      return {6'd0, idx, 2'b00};
   endfunction

   function automatic logic [15:0] crAddr(input logic [2:0] off);
      return `ACCEL_CR_BASE | {11'd0, off, 2'b00};
   endfunction

   function automatic logic [7:0] pickWritten();
      return wrList[takeBits(stimState, 16) % wrList.size()];
   endfunction

   function automatic accelTilePkg::tTileId foreignId();
      accelTilePkg::tTileId id;
      id = 8'(takeBits(stimState, 8));
      if (id == localTileId) id.x = ~id.x;              // never the local tile
      return id;
   endfunction

   function automatic accelTilePkg::tTileTrans makeTrans(input accelTilePkg::tFabOpcode op,
         input accelTilePkg::tTileId dest, input logic [15:0] addr, input logic [31:0] data);
      accelTilePkg::tTileTrans t;
      t.opcode = op;
      t.destId = dest;
      t.srcId  = 8'(takeBits(stimState, 8));           // any requester
      t.addr   = addr;
      t.data   = data;
      return t;
   endfunction

   function automatic void applyModel(input accelTilePkg::tTileTrans t);
      accelTilePkg::tTileTrans    rsp;
      accelTilePkg::tAccelOperand rd;
      logic [7:0]                 idx;
      logic [2:0]                 off;
      int                         dot;
      if (t.destId != localTileId || t.opcode == accelTilePkg::opReadRsp) return;
      idx = t.addr[9:2];
      off = t.addr[4:2];
      dot = 0;
      for (int i = 0; i < `ACCEL_MUL_NUM; i++) dot += laneProduct(i);
      if (t.opcode == accelTilePkg::opWrite) begin
         if (!t.addr[15]) begin
            modelMem[idx] = t.data;
            wrList.push_back(idx);
         end else begin
            case (off)
               `ACCEL_CR_OPA:  modelA.word = t.data;
               `ACCEL_CR_OPB:  modelB.word = t.data;
               `ACCEL_CR_ACC:  modelAcc    = t.data;
               `ACCEL_CR_STEP: modelAcc    = modelAcc + dot;   // wraps at 32 bits
               default: ;                                       // products are read only
            endcase
         end
      end else begin
         rd.word = '0;                                          // unmapped offsets
         if (!t.addr[15]) begin
            rd.word = modelMem[idx];
         end else begin
            case (off)
               `ACCEL_CR_OPA:   rd = modelA;
               `ACCEL_CR_OPB:   rd = modelB;
               `ACCEL_CR_MULLO: rd.word = {16'(laneProduct(1)), 16'(laneProduct(0))};
               `ACCEL_CR_MULHI: rd.word = {16'(laneProduct(3)), 16'(laneProduct(2))};
               `ACCEL_CR_ACC:   rd.word = modelAcc;
               default: ;
            endcase
         end
         rsp.opcode = accelTilePkg::opReadRsp;
         rsp.destId = t.srcId;                                  // back to requester
         rsp.srcId  = localTileId;
         rsp.addr   = t.addr;
         rsp.data   = rd.word;
         expQ.push_back(rsp);
         localReads++;
      end
   endfunction

   // ==========================================================
   // compare tasks and response monitor
   // ==========================================================
   task automatic compareTrans(input string name, input accelTilePkg::tTileTrans exp,
                               input accelTilePkg::tTileTrans act);
      string expHdr;
      string actHdr;
      if (exp.opcode !== act.opcode || exp.destId !== act.destId ||
          exp.srcId !== act.srcId || exp.addr !== act.addr) begin
         expHdr = $sformatf("op %0d dst %h src %h addr %h",
                            exp.opcode, exp.destId, exp.srcId, exp.addr);
         actHdr = $sformatf("op %0d dst %h src %h addr %h",
                            act.opcode, act.destId, act.srcId, act.addr);
         $display("** Error at %0t: %s expected %s, got %s", $time, name, expHdr, actHdr);
         errorCount++;
      end
   endtask

   task automatic compareData(input string name, input accelTilePkg::tAccelOperand exp,
                              input accelTilePkg::tAccelOperand act);
      if (exp.word !== act.word) begin
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp.word, act.word);
         errorCount++;
      end
   endtask

   always @(posedge Clock) begin
      if (!reset && OutFabricValid && fabReady) begin     // transfer at this edge
         rspSeen++;
         if (expQ.size() == 0) begin
            $display("response at %0t arrived with no read outstanding", $time);
            errorCount++;
         end else begin
            expRsp = expQ.pop_front();
            compareTrans("OutFabric", expRsp, OutFabric);
            compareData("OutFabric.data", expRsp.data, OutFabric.data);
         end
      end
   end

   // fabric side readiness with short gaps or long stretches
   always @(posedge Clock) begin
      if (stretchLeft != 0) begin
         stretchLeft <= stretchLeft - 1;
      end else if (longStretches) begin
         fabReady    <= takeBits(readyState, 1) != 0;
         stretchLeft <= int'(takeBits(readyState, 5));
      end else begin
         fabReady <= takeBits(readyState, 2) != 0;        // high 3 of 4
      end
   end

   always @(posedge Clock) begin
      cycleCount++;
      if (cycleCount >= CycleLimit) begin
         $display("run timed out after %0d cycles with %0d responses missing",
                  cycleCount, expQ.size());
         $display("Testbench failed");
         $finish;
      end
   end

   // ==========================================================
   // drive helpers
   // ==========================================================
   task automatic sendTrans(input accelTilePkg::tTileTrans t);
      InFabricValid <= 1'b1;
      InFabric      <= t;
      do @(posedge Clock); while (!miniCoreReady);        // accepted at this edge
      applyModel(t);
   endtask

   task automatic drainResponses();
      InFabricValid <= 1'b0;
      while (expQ.size() != 0) @(posedge Clock);
      repeat (4) @(posedge Clock);                        // catch duplicates
   endtask

   task automatic reportTest(input string name, input int startErr);
      if (errorCount == startErr) begin
         testsPassed++;
         $display("test %s: ok", name);
      end else begin
         testsFailed++;
         $display("test %s: %0d errors", name, errorCount - startErr);
      end
   endtask

   task automatic checkRspCount();
      if (rspSeen != localReads) begin
         $display("%0d responses seen for %0d local reads", rspSeen, localReads);
         errorCount++;
      end
   endtask

   // ==========================================================
   // tests
   // ==========================================================
   task automatic memRoundTrip();
      int         startErr;
      logic [7:0] idx;
      logic [7:0] addrs [$];
      startErr = errorCount;
      for (int n = 0; n < NumMemWords; n++) begin
         idx = 8'(takeBits(stimState, 8));
         addrs.push_back(idx);
         sendTrans(makeTrans(accelTilePkg::opWrite, localTileId, memAddr(idx),
                             takeBits(stimState, 32)));
      end
      foreach (addrs[i]) begin
         sendTrans(makeTrans(accelTilePkg::opRead, localTileId, memAddr(addrs[i]), '0));
      end
      drainResponses();
      reportTest("memory round trip", startErr);
   endtask

   task automatic mulLanes();
      int startErr;
      startErr = errorCount;
      for (int n = 0; n < NumMulIter; n++) begin
         sendTrans(makeTrans(accelTilePkg::opWrite, localTileId, crAddr(`ACCEL_CR_OPA),
                             takeBits(stimState, 32)));
         sendTrans(makeTrans(accelTilePkg::opWrite, localTileId, crAddr(`ACCEL_CR_OPB),
                             takeBits(stimState, 32)));
         sendTrans(makeTrans(accelTilePkg::opRead, localTileId, crAddr(`ACCEL_CR_MULLO), '0));
         sendTrans(makeTrans(accelTilePkg::opRead, localTileId, crAddr(`ACCEL_CR_MULHI), '0));
      end
      drainResponses();
      reportTest("multiplier lanes", startErr);
   endtask

   task automatic neuronMac();
      int startErr;
      int steps;
      startErr = errorCount;
      for (int r = 0; r < NumMacRound; r++) begin
         sendTrans(makeTrans(accelTilePkg::opWrite, localTileId, crAddr(`ACCEL_CR_ACC),
                             takeBits(stimState, 32)));
         steps = int'(takeBits(stimState, 5));
         if (steps == 0) steps = 1;
         for (int s = 0; s < steps; s++) begin
            sendTrans(makeTrans(accelTilePkg::opWrite, localTileId, crAddr(`ACCEL_CR_OPA),
                                takeBits(stimState, 32)));
            sendTrans(makeTrans(accelTilePkg::opWrite, localTileId, crAddr(`ACCEL_CR_OPB),
                                takeBits(stimState, 32)));
            sendTrans(makeTrans(accelTilePkg::opWrite, localTileId, crAddr(`ACCEL_CR_STEP),
                                takeBits(stimState, 32)));
         end
         sendTrans(makeTrans(accelTilePkg::opRead, localTileId, crAddr(`ACCEL_CR_ACC), '0));
      end
      drainResponses();
      reportTest("neuron mac", startErr);
   endtask

   task automatic tileFiltering();
      int          startErr;
      logic [2:0]  kind;
      logic [7:0]  idx;
      logic [31:0] data;
      startErr   = errorCount;
      localReads = 0;
      rspSeen    = 0;
      for (int n = 0; n < NumMixed; n++) begin
         kind = 3'(takeBits(stimState, 3));
         idx  = pickWritten();
         data = takeBits(stimState, 32);
         case (kind)
            3'd0:       sendTrans(makeTrans(accelTilePkg::opWrite, localTileId,
                                            memAddr(8'(takeBits(stimState, 8))), data));
            3'd1, 3'd2: sendTrans(makeTrans(accelTilePkg::opRead, localTileId,
                                            memAddr(idx), '0));
            3'd3:       sendTrans(makeTrans(accelTilePkg::opWrite, foreignId(),
                                            memAddr(idx), data));
            3'd4:       sendTrans(makeTrans(accelTilePkg::opRead, foreignId(),
                                            memAddr(idx), '0));
            3'd5:       sendTrans(makeTrans(accelTilePkg::opWrite, foreignId(),
                                            crAddr(`ACCEL_CR_ACC), data));
            default:    sendTrans(makeTrans(accelTilePkg::opReadRsp, localTileId,
                                            memAddr(idx), data));   // stray response
         endcase
      end
      sendTrans(makeTrans(accelTilePkg::opRead, localTileId, crAddr(`ACCEL_CR_ACC), '0));
      drainResponses();
      checkRspCount();
      reportTest("tile filtering", startErr);
   endtask

   task automatic backPressure();
      int startErr;
      startErr      = errorCount;
      localReads    = 0;
      rspSeen       = 0;
      longStretches <= 1'b1;
      for (int n = 0; n < NumBpReads; n++) begin
         sendTrans(makeTrans(accelTilePkg::opRead, localTileId, memAddr(pickWritten()), '0));
      end
      drainResponses();
      longStretches <= 1'b0;
      checkRspCount();
      reportTest("back-pressure", startErr);
   endtask

   // ==========================================================
   // sequence
   // ==========================================================
   initial begin
      reset         = 1'b1;
      localTileId   = 8'h25;                          // y 2, x 5
      InFabricValid = 1'b0;
      InFabric      = '0;
      fabReady      = 1'b0;
      stimState     = 32'h7973;
      readyState    = 32'h7973;
      longStretches = 1'b0;
      stretchLeft   = 0;
      modelA        = '0;
      modelB        = '0;
      modelAcc      = '0;
      errorCount    = 0;
      testsPassed   = 0;
      testsFailed   = 0;
      localReads    = 0;
      rspSeen       = 0;
      cycleCount    = 0;
      repeat (5) @(posedge Clock);
      reset <= 1'b0;
      memRoundTrip();
      mulLanes();
      neuronMac();
      tileFiltering();
      backPressure();
      errorCount += i_miniCoreAccelTop.i_miniCoreAccelTopAssertions.failCount;  // bound checks
      $display("%0d tests passed, %0d tests failed", testsPassed, testsFailed);
      if (errorCount == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb/miniCoreAccelTopAssertions.sv */
`timescale 1ns/100ps
`default_nettype none

module miniCoreAccelTopAssertions (
   input  wire logic                     Clock,
   input  wire logic                     reset,
   input  wire logic                     miniCoreReady,
   input  wire logic                     OutFabricValid,
   input  var  accelTilePkg::tTileTrans  OutFabric,
   input  wire logic                     fabReady
);

   int failCount = 0;                                 // failed assertions so far

   // ==========================================================
   // outgoing fabric handshake
   // ==========================================================
   rspHold: assert property (@(posedge Clock) disable iff (reset)
      OutFabricValid && !fabReady |=> OutFabricValid && $stable(OutFabric))
      else begin
         $error("response dropped or changed while fabReady was low");
         failCount++;
      end

   // first reset edge clears the state, so check from the second on
   rspQuietInReset: assert property (@(posedge Clock)
      reset && $past(reset) |-> !OutFabricValid)
      else begin
         $error("OutFabricValid high during reset");
         failCount++;
      end

   readyLowInReset: assert property (@(posedge Clock)
      reset && $past(reset) |-> !miniCoreReady)
      else begin
         $error("miniCoreReady high during reset");
         failCount++;
      end

endmodule

`default_nettype wire

/* source/miniCoreAccelTop.sv */
`timescale 1ns/100ps
`default_nettype none

module miniCoreAccelTop (
   input  wire logic                     Clock,
   input  wire logic                     reset,
   input  var  accelTilePkg::tTileId     localTileId,
   // ==========================================================
   // fabric
   // ==========================================================
   input  wire logic                     InFabricValid,
   input  var  accelTilePkg::tTileTrans  InFabric,
   output logic                          miniCoreReady,
   output logic                          OutFabricValid,
   output accelTilePkg::tTileTrans       OutFabric,
   input  wire logic                     fabReady
);

   accelTilePkg::tMemReq          memReq;           // port to wrapper
   logic                          memRdValid;
   accelTilePkg::tAccelOperand    memRdData;
   accelTilePkg::tAccelFarmInput  accelFarmInput;   // wrapper to farm
   accelTilePkg::tAccelFarmOutput accelFarmOutput;

   accelTileFabricPort i_accelTileFabricPort (
      .Clock          (Clock),
      .reset          (reset),
      .localTileId    (localTileId),
      .InFabricValid  (InFabricValid),
      .InFabric       (InFabric),
      .miniCoreReady  (miniCoreReady),
      .OutFabricValid (OutFabricValid),
      .OutFabric      (OutFabric),
      .fabReady       (fabReady),
      .memReq         (memReq),
      .memRdValid     (memRdValid),
      .memRdData      (memRdData)
   );

   accelTileMemWrap i_accelTileMemWrap (
      .Clock           (Clock),
      .reset           (reset),
      .memReq          (memReq),
      .memRdValid      (memRdValid),
      .memRdData       (memRdData),
      .accelFarmInput  (accelFarmInput),
      .accelFarmOutput (accelFarmOutput)
   );

   accelFarm i_accelFarm (
      .Clock           (Clock),
      .reset           (reset),
      .accelFarmInput  (accelFarmInput),
      .accelFarmOutput (accelFarmOutput)
   );

endmodule

`default_nettype wire

/* source/accelFarm.sv */
`timescale 1ns/100ps
`default_nettype none
`include "accel_tile_macros.svh"

module accelFarm (
   input  wire logic                          Clock,
   input  wire logic                          reset,
   input  var  accelTilePkg::tAccelFarmInput  accelFarmInput,
   output accelTilePkg::tAccelFarmOutput      accelFarmOutput
);

   accelTilePkg::tAccelOperand     opA;
   accelTilePkg::tAccelOperand     opB;
   accelTilePkg::tAccelOperand     opANext;
   accelTilePkg::tAccelOperand     opBNext;
   accelTilePkg::tInt16            prodNext [`ACCEL_MUL_NUM];
   accelTilePkg::tInt16            prodQ [`ACCEL_MUL_NUM];   // registered lane products
   logic signed [`ACCEL_DATA_W-1:0] acc;                     // neuron accumulator
   logic signed [`ACCEL_DATA_W-1:0] dotSum;
   logic                           wrAcc;
   logic                           wrStep;

   assign wrAcc  = accelFarmInput.wrEn & (accelFarmInput.crOffset == `ACCEL_CR_ACC);
   assign wrStep = accelFarmInput.wrEn & (accelFarmInput.crOffset == `ACCEL_CR_STEP);

   // ==========================================================
   // operands and int8 lanes
   // ==========================================================
   always_comb begin
      opANext = opA;
      opBNext = opB;
      if (accelFarmInput.wrEn && accelFarmInput.crOffset == `ACCEL_CR_OPA) begin
         opANext = accelFarmInput.wrData;
      end
      if (accelFarmInput.wrEn && accelFarmInput.crOffset == `ACCEL_CR_OPB) begin
         opBNext = accelFarmInput.wrData;
      end
   end

   // products track the operands at the same edge
   always_comb begin
      for (int i = 0; i < `ACCEL_MUL_NUM; i++) begin
         prodNext[i] = opANext.lane[i] * opBNext.lane[i];   // signed int8 x int8
      end
   end

   always_comb begin
      dotSum = '0;
      for (int i = 0; i < `ACCEL_MUL_NUM; i++) begin
         dotSum = dotSum + prodQ[i];                        // sign extended, wraps
      end
   end

   always_ff @(posedge Clock) begin
      if (reset) begin
         opA   <= '0;
         opB   <= '0;
         prodQ <= '{default: '0};
         acc   <= '0;
      end else begin
         opA   <= opANext;
         opB   <= opBNext;
         prodQ <= prodNext;
         if (wrAcc) begin
            acc <= accelFarmInput.wrData.word;              // load
         end else if (wrStep) begin
            acc <= acc + dotSum;                            // one mac step
         end
      end
   end

   // ==========================================================
   // register read, one cycle
   // ==========================================================
   always_ff @(posedge Clock) begin
      if (accelFarmInput.rdEn) begin
         case (accelFarmInput.crOffset)
            `ACCEL_CR_OPA:   accelFarmOutput.rdData <= opA;
            `ACCEL_CR_OPB:   accelFarmOutput.rdData <= opB;
            `ACCEL_CR_MULLO: accelFarmOutput.rdData.word <= {prodQ[1], prodQ[0]};
            `ACCEL_CR_MULHI: accelFarmOutput.rdData.word <= {prodQ[3], prodQ[2]};
            `ACCEL_CR_ACC:   accelFarmOutput.rdData.word <= acc;
            default:         accelFarmOutput.rdData <= '0;  // step is write only
         endcase
      end
   end

endmodule

`default_nettype wire

/* source/accelTileMemWrap.sv */
`timescale 1ns/100ps
`default_nettype none
`include "accel_tile_macros.svh"

module accelTileMemWrap (
   input  wire logic                           Clock,
   input  wire logic                           reset,
   input  var  accelTilePkg::tMemReq           memReq,
   output logic                                memRdValid,
   output accelTilePkg::tAccelOperand          memRdData,
   output accelTilePkg::tAccelFarmInput        accelFarmInput,
   input  var  accelTilePkg::tAccelFarmOutput  accelFarmOutput
);

   logic [`ACCEL_DATA_W-1:0]   dmem [`ACCEL_DMEM_WORDS];
   logic [`ACCEL_DMEM_AW-1:0]  dmemIdx;
   logic                       crSel;         // access targets the farm
   logic [`ACCEL_CR_OFF_W-1:0] crOffset;
   logic                       crMapped;      // offset has a register behind it
   logic                       rdValidQ;
   logic                       rdFarmQ;       // pending read came from the farm
   logic                       rdMappedQ;
   logic [`ACCEL_DATA_W-1:0]   dmemRdQ;

   // ==========================================================
   // address decode
   // ==========================================================
   assign crSel    = |({memReq.wordAddr, 2'b00} & `ACCEL_CR_BASE);
   assign dmemIdx  = memReq.wordAddr[`ACCEL_DMEM_AW-1:0];   // upper bits alias
   assign crOffset = memReq.wordAddr[`ACCEL_CR_OFF_W-1:0];
   assign crMapped = (crOffset <= `ACCEL_CR_STEP);

   always_comb begin
      accelFarmInput.wrEn     = memReq.wrEn & crSel;
      accelFarmInput.rdEn     = memReq.rdEn & crSel;
      accelFarmInput.crOffset = crOffset;
      accelFarmInput.wrData   = memReq.wrData;
   end

   // ==========================================================
   // data memory
   // ==========================================================
   always_ff @(posedge Clock) begin
      if (memReq.wrEn && !crSel) begin
         dmem[dmemIdx] <= memReq.wrData.word;
      end
      if (memReq.rdEn && !crSel) begin
         dmemRdQ <= dmem[dmemIdx];                   // one cycle read
      end
   end

   // return path select
   always_ff @(posedge Clock) begin
      if (reset) begin
         rdValidQ  <= 1'b0;
         rdFarmQ   <= 1'b0;
         rdMappedQ <= 1'b0;
      end else begin
         rdValidQ <= memReq.rdEn;
         if (memReq.rdEn) begin
            rdFarmQ   <= crSel;
            rdMappedQ <= crMapped;
         end
      end
   end

   assign memRdValid = rdValidQ;

   always_comb begin
      if (rdFarmQ) begin
         memRdData = rdMappedQ ? accelFarmOutput.rdData : '0;  // unmapped reads zero
      end else begin
         memRdData.word = dmemRdQ;
      end
   end

endmodule

`default_nettype wire

/* source/accelTileFabricPort.sv */
`timescale 1ns/100ps
`default_nettype none
`include "accel_tile_macros.svh"

module accelTileFabricPort (
   input  wire logic                        Clock,
   input  wire logic                        reset,
   input  var  accelTilePkg::tTileId        localTileId,
   input  wire logic                        InFabricValid,
   input  var  accelTilePkg::tTileTrans     InFabric,
   output logic                             miniCoreReady,
   output logic                             OutFabricValid,
   output accelTilePkg::tTileTrans          OutFabric,
   input  wire logic                        fabReady,
   output accelTilePkg::tMemReq             memReq,
   input  wire logic                        memRdValid,
   input  var  accelTilePkg::tAccelOperand  memRdData
);

   logic                     inAccept;      // fabric transfer this cycle
   logic                     isLocal;       // addressed to this tile
   logic                     wrAccept;
   logic                     rdAccept;
   accelTilePkg::tTileId     rdSrcId;       // requester of the read in flight
   logic [`ACCEL_ADDR_W-1:0] rdAddr;        // echoed in the response
   logic                     rdInFlight;
   logic                     rdInFlightNext;
   accelTilePkg::tTileTrans  rspFifo [2];
   accelTilePkg::tTileTrans  rspTrans;
   logic                     wrPtr;
   logic                     rdPtr;
   logic [1:0]               rspCount;      // 0..2 queued
   logic [1:0]               rspCountNext;
   logic                     rspPush;
   logic                     rspPop;
   logic                     readyNext;

   // ==========================================================
   // request filter and issue
   // ==========================================================
   assign inAccept = InFabricValid & miniCoreReady;
   assign isLocal  = (InFabric.destId == localTileId);
   assign wrAccept = inAccept & isLocal & (InFabric.opcode == accelTilePkg::opWrite);
   assign rdAccept = inAccept & isLocal & (InFabric.opcode == accelTilePkg::opRead);
   // foreign ids and stray responses are taken and dropped

   always_ff @(posedge Clock) begin
      if (reset) begin
         memReq.wrEn <= 1'b0;
         memReq.rdEn <= 1'b0;
      end else begin
         memReq.wrEn <= wrAccept;                     // single cycle pulse
         memReq.rdEn <= rdAccept;
      end
      if (wrAccept | rdAccept) begin
         memReq.wordAddr    <= InFabric.addr[`ACCEL_ADDR_W-1:2];  // byte to word
         memReq.wrData.word <= InFabric.data;
      end
   end

   always_ff @(posedge Clock) begin
      if (rdAccept) begin
         rdSrcId <= InFabric.srcId;                   // response goes back here
         rdAddr  <= InFabric.addr;
      end
   end

   // ==========================================================
   // response fifo and ready
   // ==========================================================
   always_comb begin
      rspTrans.opcode = accelTilePkg::opReadRsp;
      rspTrans.destId = rdSrcId;
      rspTrans.srcId  = localTileId;
      rspTrans.addr   = rdAddr;
      rspTrans.data   = memRdData.word;
   end

   assign rspPush        = memRdValid;                // read data back from wrapper
   assign rspPop         = OutFabricValid & fabReady;
   assign rdInFlightNext = rdAccept | (rdInFlight & ~memRdValid);

   always_comb begin
      rspCountNext = rspCount;
      if (rspPush && !rspPop) begin
         rspCountNext = rspCount + 2'd1;
      end else if (rspPop && !rspPush) begin
         rspCountNext = rspCount - 2'd1;
      end
   end

   // keep a slot for every read, and hold off while the record is still needed
   assign readyNext = ((rspCountNext + 2'(rdInFlightNext)) < 2'd2) & ~rdAccept;

   always_ff @(posedge Clock) begin
      if (reset) begin
         wrPtr         <= 1'b0;
         rdPtr         <= 1'b0;
         rspCount      <= 2'd0;
         rdInFlight    <= 1'b0;
         miniCoreReady <= 1'b0;                       // low through reset
      end else begin
         if (rspPush) wrPtr <= ~wrPtr;
         if (rspPop) rdPtr <= ~rdPtr;
         rspCount      <= rspCountNext;
         rdInFlight    <= rdInFlightNext;
         miniCoreReady <= readyNext;
      end
      if (rspPush) rspFifo[wrPtr] <= rspTrans;
   end

   assign OutFabricValid = (rspCount != 2'd0);
   assign OutFabric      = rspFifo[rdPtr];            // head holds under back-pressure

endmodule

`default_nettype wire

/* source/accelTilePkg.sv */
`default_nettype none
`include "accel_tile_macros.svh"

package accelTilePkg;

   // ==========================================================
   // fabric types
   // ==========================================================
   typedef struct packed {
      logic [`ACCEL_COORD_W-1:0] y;          // mesh row
      logic [`ACCEL_COORD_W-1:0] x;          // mesh column
   } tTileId;

   typedef enum logic [1:0] {
      opWrite   = 2'd0,                      // posted write
      opRead    = 2'd1,                      // read request
      opReadRsp = 2'd2                       // read response
   } tFabOpcode;

   typedef struct packed {
      tFabOpcode                opcode;
      tTileId                   destId;      // target tile
      tTileId                   srcId;       // requesting tile
      logic [`ACCEL_ADDR_W-1:0] addr;        // byte address
      logic [`ACCEL_DATA_W-1:0] data;
   } tTileTrans;

   // ==========================================================
   // accelerator types
   // ==========================================================
   typedef logic signed [`ACCEL_LANE_W-1:0] tInt8;   // signed so lane selects stay signed
   typedef logic signed [`ACCEL_PROD_W-1:0] tInt16;  // one lane product

   // one operand word, seen whole or as int8 lanes
   typedef union packed {
      logic signed [`ACCEL_DATA_W-1:0] word;          // accumulator view
      tInt8 [`ACCEL_MUL_NUM-1:0]       lane;          // multiplier view
   } tAccelOperand;

   typedef struct packed {
      logic                       wrEn;
      logic                       rdEn;
      logic [`ACCEL_CR_OFF_W-1:0] crOffset;           // cr word offset
      tAccelOperand               wrData;
   } tAccelFarmInput;

   typedef struct packed {
      tAccelOperand rdData;                           // valid the cycle after rdEn
   } tAccelFarmOutput;

   // port to memory wrapper, whole words only
   typedef struct packed {
      logic                        wrEn;
      logic                        rdEn;
      logic [`ACCEL_WADDR_W-1:0]   wordAddr;
      tAccelOperand                wrData;
   } tMemReq;

endpackage

`default_nettype wire

/* source/accel_tile_macros.svh */
`ifndef ACCEL_TILE_MACROS_SVH
`define ACCEL_TILE_MACROS_SVH

// ==========================================================
// data memory
// ==========================================================
`define ACCEL_DMEM_WORDS 256                 // 32-bit words
`define ACCEL_DMEM_AW    8                   // index bits into dmem

// ==========================================================
// accelerator farm
// ==========================================================
`define ACCEL_MUL_NUM    4                   // one int8 lane per operand byte
`define ACCEL_LANE_W     8                   // int8 lane
`define ACCEL_PROD_W     16                  // int8 x int8 product

// address map, byte address bit 15 picks the cr space
`define ACCEL_CR_BASE    16'h8000
`define ACCEL_CR_OFF_W   3                   // cr word offset bits
`define ACCEL_CR_OPA     3'd0                // operand a
`define ACCEL_CR_OPB     3'd1                // operand b
`define ACCEL_CR_MULLO   3'd2                // lanes 1:0 products
`define ACCEL_CR_MULHI   3'd3                // lanes 3:2 products
`define ACCEL_CR_ACC     3'd4                // mac accumulator
`define ACCEL_CR_STEP    3'd5                // write to run one mac step

// ==========================================================
// fabric fields
// ==========================================================
`define ACCEL_COORD_W    4                   // x or y coordinate
`define ACCEL_ADDR_W     16                  // byte address
`define ACCEL_WADDR_W    (`ACCEL_ADDR_W - 2) // word address
`define ACCEL_DATA_W     32

`endif
